// File: include/ntm_cfg.svh
// Float widths assume IEEE single precision; changing them needs matching testbench reference
`ifndef NTM_CFG_SVH
`define NTM_CFG_SVH

////////////////////////////////////////////////////////////
// Word and control widths
////////////////////////////////////////////////////////////

// One float word on the data bus
`define NTM_DATA_SIZE 32
// Vector length and element counter
`define NTM_CONTROL_SIZE 16

////////////////////////////////////////////////////////////
// Float field layout
////////////////////////////////////////////////////////////

`define NTM_EXP_SIZE 8
`define NTM_MAN_SIZE 23
`define NTM_EXP_BIAS 127

`endif

// File: rtl/ntm_pkg.sv
// Types only; field widths come from ntm_cfg.svh, which must be on the include path
`include "ntm_cfg.svh"

package ntm_pkg;

  ////////////////////////////////////////////////////////////
  // Float word
  ////////////////////////////////////////////////////////////

  // Sign, biased exponent, stored mantissa without hidden bit
  typedef struct packed {
    logic                     sign;
    logic [`NTM_EXP_SIZE-1:0] exponent;
    logic [`NTM_MAN_SIZE-1:0] mantissa;
  } float_t;

  ////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////

  // Element loop of the vector controller
  typedef enum logic [2:0] {
    vec_idle,
    vec_wait_vector,
    vec_wait_scalar,
    vec_multiply,
    vec_finish
  } vector_state_e;

  // Sequential float multiplier
  typedef enum logic [1:0] {
    mul_idle,
    mul_accumulate,
    mul_normalize
  } multiplier_state_e;

endpackage

// File: rtl/float_multiplier.sv
// Fixed 26-cycle latency; zero exponent is zero, truncates, no inf/NaN inputs, start only in idle
`timescale 1ns/1ps
`include "ntm_cfg.svh"

module float_multiplier (
  input  logic            CLK,
  input  logic            RST,
  input  logic            start,
  input  ntm_pkg::float_t operand_a,
  input  ntm_pkg::float_t operand_b,
  output logic            ready,
  output ntm_pkg::float_t product
);

  ////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////

  // Mantissa with hidden bit, and the full double-width product
  localparam int SIG_W  = `NTM_MAN_SIZE + 1;
  localparam int PROD_W = 2 * SIG_W;
  // Two guard bits keep the exponent sum signed and free of wrap
  localparam int EXP_W  = `NTM_EXP_SIZE + 2;
  localparam int CNT_W  = $clog2(SIG_W);

  localparam logic [CNT_W-1:0]        LAST_BIT = CNT_W'(SIG_W - 1);
  localparam logic signed [EXP_W-1:0] BIAS     = EXP_W'(`NTM_EXP_BIAS);
  localparam logic signed [EXP_W-1:0] EXP_MAX  = EXP_W'((1 << `NTM_EXP_SIZE) - 1);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ntm_pkg::multiplier_state_e state;
  logic [CNT_W-1:0]           count;

  // Unpacked operands
  logic                       sign_q;
  logic                       zero_q;
  logic signed [EXP_W-1:0]    exp_sum;
  logic [PROD_W-1:0]          mcand;
  logic [SIG_W-1:0]           mplier;
  logic [PROD_W-1:0]          acc;

  // Normalize stage
  logic signed [EXP_W-1:0]    norm_exp;
  logic [`NTM_MAN_SIZE-1:0]   norm_man;
  ntm_pkg::float_t            result;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_pkg::mul_idle;
      count <= '0;
      ready <= 1'b0;
    end else begin
      case (state)
        ntm_pkg::mul_idle: begin
          if (start) begin
            count <= '0;
            state <= ntm_pkg::mul_accumulate;
          end
        end
        ntm_pkg::mul_accumulate: begin
          // One multiplier bit per cycle
          count <= count + 1'b1;
          if (count == LAST_BIT) begin
            state <= ntm_pkg::mul_normalize;
          end
        end
        ntm_pkg::mul_normalize: begin
          // First cycle packs, second cycle shows ready
          if (ready) begin
            ready <= 1'b0;
            state <= ntm_pkg::mul_idle;
          end else begin
            ready <= 1'b1;
          end
        end
        default: begin
          state <= ntm_pkg::mul_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Unpack on start
    if (state == ntm_pkg::mul_idle && start) begin
      sign_q  <= operand_a.sign ^ operand_b.sign;
      zero_q  <= (operand_a.exponent == '0) || (operand_b.exponent == '0);
      exp_sum <= $signed({2'b00, operand_a.exponent}) +
                 $signed({2'b00, operand_b.exponent}) - BIAS;
      mcand   <= {{SIG_W{1'b0}}, 1'b1, operand_a.mantissa};
      mplier  <= {1'b1, operand_b.mantissa};
      acc     <= '0;
    end
    // Shift-and-add, LSB of multiplier first
    if (state == ntm_pkg::mul_accumulate) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
    // Product held until the next start
    if (state == ntm_pkg::mul_normalize && !ready) begin
      product <= result;
    end
  end

  // Product of two 1.x values lies in [1,4)
  always_comb begin
    if (acc[PROD_W-1]) begin
      norm_man = acc[PROD_W-2 -: `NTM_MAN_SIZE];
      norm_exp = exp_sum + 2'sd1;
    end else begin
      norm_man = acc[PROD_W-3 -: `NTM_MAN_SIZE];
      norm_exp = exp_sum;
    end
    result.sign = sign_q;
    if (zero_q || norm_exp <= 0) begin
      // Zero input or underflow, signed zero
      result.exponent = '0;
      result.mantissa = '0;
    end else if (norm_exp >= EXP_MAX) begin
      // Saturate to infinity
      result.exponent = '1;
      result.mantissa = '0;
    end else begin
      result.exponent = norm_exp[`NTM_EXP_SIZE-1:0];
      result.mantissa = norm_man;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Ready only on the second normalize cycle
  assert property (@(posedge CLK) disable iff (RST)
    ready |-> (state == ntm_pkg::mul_normalize) && ($past(state) == ntm_pkg::mul_normalize));

  // Controller never restarts a busy multiplier
  assert property (@(posedge CLK) disable iff (RST)
    start |-> state == ntm_pkg::mul_idle);

endmodule

// File: rtl/vector_multiplication_ctrl.sv
// Plain strobes, no back-pressure; strobes outside the matching wait state and busy starts are dropped
`timescale 1ns/1ps
`include "ntm_cfg.svh"

module vector_multiplication_ctrl (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         start,
  input  logic [`NTM_CONTROL_SIZE-1:0] length_in,
  input  ntm_pkg::float_t              data_in,
  input  logic                         data_in_vector_enable,
  input  logic                         data_in_scalar_enable,
  output logic                         mult_start,
  output ntm_pkg::float_t              operand_a,
  output ntm_pkg::float_t              operand_b,
  input  logic                         mult_ready,
  input  ntm_pkg::float_t              product,
  output ntm_pkg::float_t              data_out,
  output logic                         data_out_enable,
  output logic                         ready
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ntm_pkg::vector_state_e         state;
  // Length of the running vector and elements done so far
  logic [`NTM_CONTROL_SIZE-1:0]   length_q;
  logic [`NTM_CONTROL_SIZE-1:0]   index;
  logic                           last_element;

  assign last_element = (index == length_q - 1'b1);

  ////////////////////////////////////////////////////////////
  // Element loop
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ntm_pkg::vec_idle;
      length_q        <= '0;
      index           <= '0;
      mult_start      <= 1'b0;
      data_out        <= '0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // Pulses default low
      mult_start      <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        ntm_pkg::vec_idle: begin
          if (start) begin
            length_q <= length_in;
            index    <= '0;
            if (length_in == '0) begin
              // Empty vector, ready right away
              ready <= 1'b1;
              state <= ntm_pkg::vec_finish;
            end else begin
              state <= ntm_pkg::vec_wait_vector;
            end
          end
        end
        ntm_pkg::vec_wait_vector: begin
          if (data_in_vector_enable) begin
            state <= ntm_pkg::vec_wait_scalar;
          end
        end
        ntm_pkg::vec_wait_scalar: begin
          // Pair complete, kick the multiplier next cycle
          if (data_in_scalar_enable) begin
            mult_start <= 1'b1;
            state      <= ntm_pkg::vec_multiply;
          end
        end
        ntm_pkg::vec_multiply: begin
          if (mult_ready) begin
            data_out        <= product;
            data_out_enable <= 1'b1;
            if (last_element) begin
              ready <= 1'b1;
              state <= ntm_pkg::vec_finish;
            end else begin
              index <= index + 1'b1;
              state <= ntm_pkg::vec_wait_vector;
            end
          end
        end
        ntm_pkg::vec_finish: begin
          // Ready visible here, then back to idle
          state <= ntm_pkg::vec_idle;
        end
        default: begin
          state <= ntm_pkg::vec_idle;
        end
      endcase
    end
  end

  // Operand registers
  always_ff @(posedge CLK) begin
    if (state == ntm_pkg::vec_wait_vector && data_in_vector_enable) begin
      operand_a <= data_in;
    end
    if (state == ntm_pkg::vec_wait_scalar && data_in_scalar_enable) begin
      operand_b <= data_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Output product only right after a multiply
  assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> $past(state) == ntm_pkg::vec_multiply);

  // Ready marks the last product, or an empty vector
  assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_enable ||
              $past(start && length_in == '0 && state == ntm_pkg::vec_idle));

endmodule

// File: rtl/vector_multiplication.sv
// Element-wise float product; one pair in flight at a time, 28 cycles from scalar strobe to output
`timescale 1ns/1ps
`include "ntm_cfg.svh"

module vector_multiplication (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         start,
  input  logic [`NTM_CONTROL_SIZE-1:0] length_in,
  input  ntm_pkg::float_t              data_in,
  input  logic                         data_in_vector_enable,
  input  logic                         data_in_scalar_enable,
  output ntm_pkg::float_t              data_out,
  output logic                         data_out_enable,
  output logic                         ready
);

  ////////////////////////////////////////////////////////////
  // Controller to multiplier
  ////////////////////////////////////////////////////////////

  logic            mult_start;
  logic            mult_ready;
  ntm_pkg::float_t operand_a;
  ntm_pkg::float_t operand_b;
  ntm_pkg::float_t product;

  // Element loop
  vector_multiplication_ctrl ctrl (
    .CLK                  (CLK),
    .RST                  (RST),
    .start                (start),
    .length_in            (length_in),
    .data_in              (data_in),
    .data_in_vector_enable(data_in_vector_enable),
    .data_in_scalar_enable(data_in_scalar_enable),
    .mult_start           (mult_start),
    .operand_a            (operand_a),
    .operand_b            (operand_b),
    .mult_ready           (mult_ready),
    .product              (product),
    .data_out             (data_out),
    .data_out_enable      (data_out_enable),
    .ready                (ready)
  );

  // Sequential multiplier
  float_multiplier multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .start    (mult_start),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .ready    (mult_ready),
    .product  (product)
  );

endmodule

// File: verif/vector_multiplication_tb.sv
// Needs include/ on the include path; random operands keep exponents in 64..190, no inf or NaN
`timescale 1ns/1ps
`include "ntm_cfg.svh"

module vector_multiplication_tb;

  ////////////////////////////////////////////////////////////
  // Run length
  ////////////////////////////////////////////////////////////

  localparam int RANDOM_VECTORS  = 20;
  localparam int MAX_RANDOM_LEN  = 8;
  // Directed, special, random, ready and disturbed vectors
  localparam int MAX_ELEMENTS    = 4 + 4 + RANDOM_VECTORS * MAX_RANDOM_LEN + 3 + 4;
  localparam int WATCHDOG_CYCLES = MAX_ELEMENTS * 40 + 1000;
  // Scalar strobe cycle to data_out_enable cycle
  localparam int LATENCY         = 28;

  logic                         CLK = 1'b0;
  logic                         RST;
  logic                         start;
  logic [`NTM_CONTROL_SIZE-1:0] length_in;
  ntm_pkg::float_t              data_in;
  logic                         data_in_vector_enable;
  logic                         data_in_scalar_enable;
  ntm_pkg::float_t              data_out;
  logic                         data_out_enable;
  logic                         ready;

  // Scoreboard, filled by the driver and drained by the checker
  ntm_pkg::float_t expected_q[$];
  int              strobe_cycle_q[$];
  ntm_pkg::float_t vec_a[$];
  ntm_pkg::float_t vec_b[$];
  int              cycle = 0;
  int              product_count = 0;
  int              ready_count = 0;
  int              ready_cycle = -1;
  int              last_enable_cycle = -1;
  int              start_cycle = -1;
  bit              started = 1'b0;
  // Totals and per-test bases
  int              pass_count = 0;
  int              fail_count = 0;
  int              test_index = 0;
  int              test_pass_base = 0;
  int              test_fail_base = 0;
  logic [31:0]     rng_state = 32'h3b79;

  vector_multiplication UUT (
    .CLK                  (CLK),
    .RST                  (RST),
    .start                (start),
    .length_in            (length_in),
    .data_in              (data_in),
    .data_in_vector_enable(data_in_vector_enable),
    .data_in_scalar_enable(data_in_scalar_enable),
    .data_out             (data_out),
    .data_out_enable      (data_out_enable),
    .ready                (ready)
  );

  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and random source
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Exponent in 64..190, so no overflow from random pairs
  function automatic ntm_pkg::float_t rand_float();
    logic [31:0]     r;
    ntm_pkg::float_t f;
    r          = next_random();
    f.sign     = r[31];
    f.exponent = 8'(64 + r[30:23] % 127);
    f.mantissa = r[22:0];
    return f;
  endfunction

  // Truncating product; zero exponent reads as zero
  function automatic ntm_pkg::float_t ref_fmul(input ntm_pkg::float_t a,
                                               input ntm_pkg::float_t b);
    logic [47:0]     sig_a;
    logic [47:0]     sig_b;
    logic [47:0]     full;
    int              e_sum;
    ntm_pkg::float_t r;
    r      = '0;
    r.sign = a.sign ^ b.sign;
    if (a.exponent == 0 || b.exponent == 0) begin
      return r;
    end
    sig_a = {24'd0, 1'b1, a.mantissa};
    sig_b = {24'd0, 1'b1, b.mantissa};
    full  = sig_a * sig_b;
    e_sum = int'(a.exponent) + int'(b.exponent) - `NTM_EXP_BIAS;
    // Value in [2,4) moves the point one place
    if (full[47]) begin
      e_sum      = e_sum + 1;
      r.mantissa = full[46:24];
    end else begin
      r.mantissa = full[45:23];
    end
    if (e_sum <= 0) begin
      r.mantissa = '0;
    end else if (e_sum >= 255) begin
      r.exponent = '1;
      r.mantissa = '0;
    end else begin
      r.exponent = e_sum[7:0];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic count_pass();
    pass_count++;
  endtask

  task automatic log_mismatch(input string msg);
    fail_count++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic note_fault(input string msg);
    fail_count++;
    $display("at %0t ns the DUT failed: %s", $time, msg);
  endtask

  task automatic close_test(input string name);
    test_index++;
    $display("test %0d %s: %0d checks passed, %0d failed", test_index, name,
             pass_count - test_pass_base, fail_count - test_fail_base);
    test_pass_base = pass_count;
    test_fail_base = fail_count;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic send_start(input int len);
    start       = 1'b1;
    length_in   = `NTM_CONTROL_SIZE'(len);
    started     = 1'b1;
    start_cycle = cycle;
    tick(1);
    start = 1'b0;
  endtask

  task automatic send_pair(input ntm_pkg::float_t a, input ntm_pkg::float_t b,
                           input bit disturb);
    int target;
    int waited;
    target                = product_count + 1;
    waited                = 0;
    data_in               = a;
    data_in_vector_enable = 1'b1;
    tick(1);
    data_in_vector_enable = 1'b0;
    data_in               = next_random();
    tick(2);
    if (disturb) begin
      // Stray vector strobe in wait_scalar
      data_in_vector_enable = 1'b1;
      tick(1);
      data_in_vector_enable = 1'b0;
      tick(1);
    end
    data_in               = b;
    data_in_scalar_enable = 1'b1;
    expected_q.push_back(ref_fmul(a, b));
    strobe_cycle_q.push_back(cycle);
    tick(1);
    data_in_scalar_enable = 1'b0;
    data_in               = next_random();
    if (disturb) begin
      // Strobes and a restart while the multiplier runs
      tick(4);
      data_in_vector_enable = 1'b1;
      start                 = 1'b1;
      length_in             = 5;
      tick(1);
      data_in_vector_enable = 1'b0;
      start                 = 1'b0;
      tick(2);
      data_in_scalar_enable = 1'b1;
      tick(1);
      data_in_scalar_enable = 1'b0;
    end
    while (product_count < target && waited < 2 * LATENCY) begin
      tick(1);
      waited++;
    end
    if (product_count < target) begin
      note_fault("no data_out_enable followed the scalar strobe");
    end
  endtask

  task automatic add_pair(input ntm_pkg::float_t a, input ntm_pkg::float_t b);
    vec_a.push_back(a);
    vec_b.push_back(b);
  endtask

  // Known result also cross-checks the reference
  task automatic add_known(input logic [31:0] a, input logic [31:0] b, input logic [31:0] lit);
    if (ref_fmul(a, b) !== lit) begin
      log_mismatch($sformatf("reference %h x %h gave %h, expected %h", a, b, ref_fmul(a, b), lit));
    end else begin
      count_pass();
    end
    add_pair(a, b);
  endtask

  // One whole vector, then product count and ready timing
  task automatic run_vector(input bit disturb);
    int len;
    int ready_base;
    int product_base;
    int want_ready;
    len          = vec_a.size();
    ready_base   = ready_count;
    product_base = product_count;
    send_start(len);
    for (int i = 0; i < len; i++) begin
      send_pair(vec_a[i], vec_b[i], disturb);
    end
    tick(2);
    want_ready = (len == 0) ? start_cycle + 1 : last_enable_cycle;
    if (product_count - product_base != len) begin
      note_fault($sformatf("%0d products for a vector of %0d", product_count - product_base, len));
    end else begin
      count_pass();
    end
    if (ready_count - ready_base != 1) begin
      note_fault("ready did not pulse exactly once for the vector");
    end else if (ready_cycle != want_ready) begin
      note_fault("ready pulsed in the wrong cycle");
    end else begin
      count_pass();
    end
    vec_a.delete();
    vec_b.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // Output checker
  ////////////////////////////////////////////////////////////

  // Falling edge, well away from input and output changes
  always @(negedge CLK) begin
    ntm_pkg::float_t want;
    int              strobe_at;
    if (!started && (ready !== 1'b0 || data_out_enable !== 1'b0)) begin
      note_fault("ready or data_out_enable left low state before the first start");
    end
    if (data_out_enable === 1'b1) begin
      product_count++;
      last_enable_cycle = cycle;
      if (expected_q.size() == 0) begin
        note_fault("data_out_enable pulsed with no product outstanding");
      end else begin
        want      = expected_q.pop_front();
        strobe_at = strobe_cycle_q.pop_front();
        if (data_out !== want) begin
          log_mismatch($sformatf("product %h, expected %h", data_out, want));
        end else begin
          count_pass();
        end
        if (cycle - strobe_at != LATENCY) begin
          log_mismatch($sformatf("latency %0d cycles, expected %0d", cycle - strobe_at, LATENCY));
        end else begin
          count_pass();
        end
      end
    end
    if (ready === 1'b1) begin
      ready_count++;
      ready_cycle = cycle;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    ntm_pkg::float_t a;
    ntm_pkg::float_t b;
    int              len;
    RST                   = 1'b1;
    start                 = 1'b0;
    length_in             = '0;
    data_in               = '0;
    data_in_vector_enable = 1'b0;
    data_in_scalar_enable = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Quiet outputs until the first start
    repeat (10) begin
      tick(1);
      if (ready !== 1'b0 || data_out_enable !== 1'b0 || data_out !== '0) begin
        note_fault("outputs not quiet after reset");
      end else begin
        count_pass();
      end
    end
    close_test("reset");

    // 1.5x2.0, -3.0x0.5, mixed signs, 1.5x1.5 needs the shift
    add_known(32'h3fc00000, 32'h40000000, 32'h40400000);
    add_known(32'hc0400000, 32'h3f000000, 32'hbfc00000);
    add_known(32'h40200000, 32'hc0800000, 32'hc1200000);
    add_known(32'h3fc00000, 32'h3fc00000, 32'h40100000);
    run_vector(1'b0);
    close_test("directed");

    // Zero, negative denormal, overflow, underflow
    add_known(32'h00000000, 32'h40400000, 32'h00000000);
    add_known(32'h80000123, 32'h40000000, 32'h80000000);
    add_known(32'h64000000, 32'he4000000, 32'hff800000);
    add_known(32'h0a000000, 32'h0f000000, 32'h00000000);
    run_vector(1'b0);
    close_test("special values");

    for (int v = 0; v < RANDOM_VECTORS; v++) begin
      len = 1 + next_random() % MAX_RANDOM_LEN;
      repeat (len) begin
        a = rand_float();
        b = rand_float();
        add_pair(a, b);
      end
      run_vector(1'b0);
    end
    close_test("random vectors");

    // Empty vector, then ready with the last product
    run_vector(1'b0);
    repeat (3) begin
      a = rand_float();
      b = rand_float();
      add_pair(a, b);
    end
    run_vector(1'b0);
    close_test("ready timing");

    repeat (4) begin
      a = rand_float();
      b = rand_float();
      add_pair(a, b);
    end
    run_vector(1'b1);
    close_test("ignored strobes");

    $display("summary: %0d checks passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
rtl/ntm_pkg.sv
rtl/float_multiplier.sv
rtl/vector_multiplication_ctrl.sv
rtl/vector_multiplication.sv
verif/vector_multiplication_tb.sv

// File: Makefile
# Verilator build and run of the vector multiplier testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary -j 0 --assert -Wno-fatal --timescale 1ns/1ps -f tb.f \
	  --top-module vector_multiplication_tb --Mdir obj_dir -o vector_multiplication_tb
	./obj_dir/vector_multiplication_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	  if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then \
	    echo "test: FAIL"; exit 1; \
	  fi
	@echo "test: PASS"

clean:
	rm -rf obj_dir $(LOG)
